//--- design/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define XLEN            32
`define CSR_ADDR_BITS   12
`define NUM_WARPS       4
`define NW_BITS         2
`define NUM_THREADS     4
`define NUM_CORES       2
`define NUM_CLUSTERS    1
`define PERF_CTR_BITS   44
`define FFLAGS_BITS     5
`define FRM_BITS        3
`define RD_CLASS_BITS   5
`define MACH_IDX_BITS   4
`define MACH_REGS       9

// Extensions I, M and F
`define MISA_STD        32'h0000_1120
`define VENDOR_ID       32'h0000_0000
`define ARCH_ID         32'h0000_0001
`define IMPL_ID         32'h0000_0002

// Floating-point CSRs
`define CSR_FFLAGS      12'h001
`define CSR_FRM         12'h002
`define CSR_FCSR        12'h003

// Machine CSRs
`define CSR_SATP        12'h180
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MEDELEG     12'h302
`define CSR_MIDELEG     12'h303
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_PMPCFG0     12'h3A0
`define CSR_PMPADDR0    12'h3B0
`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12
`define CSR_MIMPID      12'hF13

// Core-specific identity CSRs
`define CSR_LWID        12'hCC0
`define CSR_GWID        12'hCC1
`define CSR_GCID        12'hCC2
`define CSR_TMASK       12'hCC3
`define CSR_NT          12'hFC0
`define CSR_NW          12'hFC1
`define CSR_NC          12'hFC2

// Monitor windows, counters sit at the bottom of each
`define CSR_MPM_BASE    12'hB00
`define CSR_MPM_BASE_H  12'hB80
`define MPM_WINDOW      32
`define CSR_MCYCLE      12'hB00
`define CSR_MCYCLE_H    12'hB80
`define CSR_MINSTRET    12'hB02
`define CSR_MINSTRET_H  12'hB82

// Read class codes
`define RD_NONE         5'd0
`define RD_FFLAGS       5'd1
`define RD_FRM          5'd2
`define RD_FCSR         5'd3
`define RD_MACH         5'd4
`define RD_LWID         5'd5
`define RD_GWID         5'd6
`define RD_GCID         5'd7
`define RD_TMASK        5'd8
`define RD_NT           5'd9
`define RD_NW           5'd10
`define RD_NC           5'd11
`define RD_MISA         5'd12
`define RD_VENDOR       5'd13
`define RD_ARCH         5'd14
`define RD_IMPL         5'd15
`define RD_CYCLE_L      5'd16
`define RD_CYCLE_H      5'd17
`define RD_INSTRET_L    5'd18
`define RD_INSTRET_H    5'd19
`define RD_ZERO         5'd20

// Machine register slots
`define MI_SATP         4'd0
`define MI_MSTATUS      4'd1
`define MI_MEDELEG      4'd2
`define MI_MIDELEG      4'd3
`define MI_MIE          4'd4
`define MI_MTVEC        4'd5
`define MI_MEPC         4'd6
`define MI_PMPCFG0      4'd7
`define MI_PMPADDR0     4'd8
`define MI_NONE         4'd15

`endif

//--- design/csr_decode.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_decode (
    input  logic                write_enable,
    input  csr_pkg::csr_addr_t  write_addr,
    input  csr_pkg::csr_addr_t  read_addr,
    output logic                wr_fflags,
    output logic                wr_frm,
    output logic                wr_fcsr,
    output csr_pkg::mach_sel_t  wr_mach_sel,
    output csr_pkg::mach_idx_t  rd_mach_idx,
    output csr_pkg::rd_class_t  rd_class,
    output logic                read_addr_valid
);
    import csr_pkg::*;

    mach_idx_t wr_idx;
    logic      in_mpm_window;

    // Slot of a writable machine CSR, MI_NONE otherwise
    function automatic mach_idx_t mach_lookup(input csr_addr_t addr);
        case (addr)
            `CSR_SATP:     mach_lookup = `MI_SATP;
            `CSR_MSTATUS:  mach_lookup = `MI_MSTATUS;
            `CSR_MEDELEG:  mach_lookup = `MI_MEDELEG;
            `CSR_MIDELEG:  mach_lookup = `MI_MIDELEG;
            `CSR_MIE:      mach_lookup = `MI_MIE;
            `CSR_MTVEC:    mach_lookup = `MI_MTVEC;
            `CSR_MEPC:     mach_lookup = `MI_MEPC;
            `CSR_PMPCFG0:  mach_lookup = `MI_PMPCFG0;
            `CSR_PMPADDR0: mach_lookup = `MI_PMPADDR0;
            default:       mach_lookup = `MI_NONE;
        endcase
    endfunction

    // Write side, unknown addresses raise no strobe
    assign wr_fflags = write_enable && (write_addr == `CSR_FFLAGS);
    assign wr_frm    = write_enable && (write_addr == `CSR_FRM);
    assign wr_fcsr   = write_enable && (write_addr == `CSR_FCSR);

    assign wr_idx      = mach_lookup(write_addr);
    assign wr_mach_sel = (write_enable && (wr_idx != `MI_NONE)) ?
                         (mach_sel_t'(1) << wr_idx) : '0;

    // Read side
    assign rd_mach_idx = mach_lookup(read_addr);

    assign in_mpm_window =
        ((read_addr >= `CSR_MPM_BASE) && (read_addr < `CSR_MPM_BASE + `MPM_WINDOW))
        || ((read_addr >= `CSR_MPM_BASE_H) && (read_addr < `CSR_MPM_BASE_H + `MPM_WINDOW));

    always_comb begin
        rd_class        = `RD_NONE;
        read_addr_valid = 1'b1;
        case (read_addr)
            `CSR_FFLAGS:     rd_class = `RD_FFLAGS;
            `CSR_FRM:        rd_class = `RD_FRM;
            `CSR_FCSR:       rd_class = `RD_FCSR;
            `CSR_LWID:       rd_class = `RD_LWID;
            `CSR_GWID:       rd_class = `RD_GWID;
            `CSR_GCID:       rd_class = `RD_GCID;
            `CSR_TMASK:      rd_class = `RD_TMASK;
            `CSR_NT:         rd_class = `RD_NT;
            `CSR_NW:         rd_class = `RD_NW;
            `CSR_NC:         rd_class = `RD_NC;
            `CSR_MISA:       rd_class = `RD_MISA;
            `CSR_MVENDORID:  rd_class = `RD_VENDOR;
            `CSR_MARCHID:    rd_class = `RD_ARCH;
            `CSR_MIMPID:     rd_class = `RD_IMPL;
            `CSR_MCYCLE:     rd_class = `RD_CYCLE_L;
            `CSR_MCYCLE_H:   rd_class = `RD_CYCLE_H;
            `CSR_MINSTRET:   rd_class = `RD_INSTRET_L;
            `CSR_MINSTRET_H: rd_class = `RD_INSTRET_H;
            default: begin
                if (rd_mach_idx != `MI_NONE) begin
                    rd_class = `RD_MACH;
                end else if (in_mpm_window) begin
                    // Monitor counters are not built, slots read as zero
                    rd_class = `RD_ZERO;
                end else begin
                    read_addr_valid = 1'b0;
                end
            end
        endcase
    end

endmodule

//--- design/csr_fcsr_bank.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_fcsr_bank (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_fflags,
    input  logic              wr_frm,
    input  logic              wr_fcsr,
    input  csr_pkg::wid_t     write_wid,
    input  csr_pkg::xlen_t    write_data,
    input  logic              fpu_write_enable,
    input  csr_pkg::wid_t     fpu_write_wid,
    input  csr_pkg::fflags_t  fpu_write_fflags,
    input  csr_pkg::wid_t     read_wid,
    input  csr_pkg::wid_t     fpu_read_wid,
    output csr_pkg::fflags_t  rd_fflags,
    output csr_pkg::frm_t     rd_frm,
    output csr_pkg::frm_t     fpu_read_frm
);
    import csr_pkg::*;

    fflags_t [`NUM_WARPS-1:0] warp_fflags;
    frm_t    [`NUM_WARPS-1:0] warp_frm;

    always_ff @(posedge clk) begin
        if (reset) begin
            warp_fflags <= '0;
            warp_frm    <= '0;
        end else begin
            // Accumulate FPU exceptions
            if (fpu_write_enable) begin
                warp_fflags[fpu_write_wid] <= warp_fflags[fpu_write_wid] | fpu_write_fflags;
            end
            // Later assignment wins, so a software flag write overrides the OR
            if (wr_fflags || wr_fcsr) begin
                warp_fflags[write_wid] <= write_data[`FFLAGS_BITS-1:0];
            end
            if (wr_frm) begin
                warp_frm[write_wid] <= write_data[`FRM_BITS-1:0];
            end
            if (wr_fcsr) begin
                warp_frm[write_wid] <= write_data[`FFLAGS_BITS +: `FRM_BITS];
            end
        end
    end

    assign rd_fflags    = warp_fflags[read_wid];
    assign rd_frm       = warp_frm[read_wid];

    // Rounding mode for the FPU's own warp
    assign fpu_read_frm = warp_frm[fpu_read_wid];

endmodule

//--- design/csr_mach_regs.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_mach_regs (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::mach_sel_t  wr_mach_sel,
    input  csr_pkg::xlen_t      write_data,
    input  csr_pkg::mach_idx_t  rd_mach_idx,
    output csr_pkg::xlen_t      rd_mach_data
);
    import csr_pkg::*;

    // satp, mstatus, medeleg, mideleg, mie, mtvec, mepc, pmpcfg0, pmpaddr0
    xlen_t [`MACH_REGS-1:0] regs;

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else begin
            for (int i = 0; i < `MACH_REGS; i++) begin
                if (wr_mach_sel[i]) begin
                    regs[i] <= write_data;
                end
            end
        end
    end

    // Index outside the file reads zero
    always_comb begin
        rd_mach_data = '0;
        for (int i = 0; i < `MACH_REGS; i++) begin
            if (rd_mach_idx == mach_idx_t'(i)) begin
                rd_mach_data = regs[i];
            end
        end
    end

endmodule

//--- design/csr_pkg.sv
`include "csr_consts.svh"

package csr_pkg;

    typedef logic [`XLEN-1:0]           xlen_t;
    typedef logic [`CSR_ADDR_BITS-1:0]  csr_addr_t;
    typedef logic [`NW_BITS-1:0]        wid_t;
    typedef logic [`NUM_THREADS-1:0]    tmask_t;

    // Floating-point status fields
    typedef logic [`FFLAGS_BITS-1:0]    fflags_t;
    typedef logic [`FRM_BITS-1:0]       frm_t;

    typedef logic [`PERF_CTR_BITS-1:0]  perf_ctr_t;

    // Decoder outputs
    typedef logic [`RD_CLASS_BITS-1:0]  rd_class_t;
    typedef logic [`MACH_IDX_BITS-1:0]  mach_idx_t;
    typedef logic [`MACH_REGS-1:0]      mach_sel_t;

endpackage

//--- design/csr_read_mux.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_read_mux #(
    parameter int CORE_ID = 0
) (
    input  csr_pkg::rd_class_t  rd_class,
    input  csr_pkg::wid_t       read_wid,
    input  csr_pkg::tmask_t     read_tmask,
    input  csr_pkg::perf_ctr_t  cycles,
    input  csr_pkg::perf_ctr_t  instret,
    input  csr_pkg::fflags_t    rd_fflags,
    input  csr_pkg::frm_t       rd_frm,
    input  csr_pkg::xlen_t      rd_mach_data,
    output csr_pkg::xlen_t      read_data_ro,
    output csr_pkg::xlen_t      read_data_rw
);
    import csr_pkg::*;

    xlen_t gwid;
    xlen_t misa;

    assign gwid = (xlen_t'(CORE_ID) << `NW_BITS) + xlen_t'(read_wid);

    // Width code lives in the top two bits
    assign misa = (xlen_t'($clog2(`XLEN) - 4) << (`XLEN - 2)) | `MISA_STD;

    always_comb begin
        read_data_ro = '0;
        read_data_rw = '0;
        case (rd_class)
            `RD_FFLAGS:    read_data_rw = xlen_t'(rd_fflags);
            `RD_FRM:       read_data_rw = xlen_t'(rd_frm);
            `RD_FCSR:      read_data_rw = xlen_t'({rd_frm, rd_fflags});
            `RD_MACH:      read_data_ro = rd_mach_data;
            `RD_LWID:      read_data_ro = xlen_t'(read_wid);
            `RD_GWID:      read_data_ro = gwid;
            `RD_GCID:      read_data_ro = xlen_t'(CORE_ID);
            `RD_TMASK:     read_data_ro = xlen_t'(read_tmask);
            `RD_NT:        read_data_ro = xlen_t'(`NUM_THREADS);
            `RD_NW:        read_data_ro = xlen_t'(`NUM_WARPS);
            `RD_NC:        read_data_ro = xlen_t'(`NUM_CORES * `NUM_CLUSTERS);
            `RD_MISA:      read_data_ro = misa;
            `RD_VENDOR:    read_data_ro = `VENDOR_ID;
            `RD_ARCH:      read_data_ro = `ARCH_ID;
            `RD_IMPL:      read_data_ro = `IMPL_ID;
            `RD_CYCLE_L:   read_data_ro = cycles[`XLEN-1:0];
            `RD_CYCLE_H:   read_data_ro = xlen_t'(cycles[`PERF_CTR_BITS-1:`XLEN]);
            `RD_INSTRET_L: read_data_ro = instret[`XLEN-1:0];
            `RD_INSTRET_H: read_data_ro = xlen_t'(instret[`PERF_CTR_BITS-1:`XLEN]);
            // ZERO and NONE leave both outputs at zero
            default: ;
        endcase
    end

endmodule

//--- design/csr_unit.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_unit #(
    parameter int CORE_ID = 0
) (
    input  logic                clk,
    input  logic                reset,

    // read_enable qualifies the read for the requester only
    input  logic                read_enable,
    input  csr_pkg::wid_t       read_wid,
    input  csr_pkg::tmask_t     read_tmask,
    input  csr_pkg::csr_addr_t  read_addr,
    output csr_pkg::xlen_t      read_data_ro,
    output csr_pkg::xlen_t      read_data_rw,
    output logic                read_addr_valid,

    input  logic                write_enable,
    input  csr_pkg::wid_t       write_wid,
    input  csr_pkg::csr_addr_t  write_addr,
    input  csr_pkg::xlen_t      write_data,

    input  logic                fpu_write_enable,
    input  csr_pkg::wid_t       fpu_write_wid,
    input  csr_pkg::fflags_t    fpu_write_fflags,
    input  csr_pkg::wid_t       fpu_read_wid,
    output csr_pkg::frm_t       fpu_read_frm,

    input  csr_pkg::perf_ctr_t  cycles,
    input  csr_pkg::perf_ctr_t  instret
);
    import csr_pkg::*;

    logic      wr_fflags;
    logic      wr_frm;
    logic      wr_fcsr;
    mach_sel_t wr_mach_sel;
    mach_idx_t rd_mach_idx;
    rd_class_t rd_class;
    fflags_t   rd_fflags;
    frm_t      rd_frm;
    xlen_t     rd_mach_data;

    csr_decode csr_decode_inst (
        .write_enable    (write_enable),
        .write_addr      (write_addr),
        .read_addr       (read_addr),
        .wr_fflags       (wr_fflags),
        .wr_frm          (wr_frm),
        .wr_fcsr         (wr_fcsr),
        .wr_mach_sel     (wr_mach_sel),
        .rd_mach_idx     (rd_mach_idx),
        .rd_class        (rd_class),
        .read_addr_valid (read_addr_valid)
    );

    csr_fcsr_bank csr_fcsr_bank_inst (
        .clk              (clk),
        .reset            (reset),
        .wr_fflags        (wr_fflags),
        .wr_frm           (wr_frm),
        .wr_fcsr          (wr_fcsr),
        .write_wid        (write_wid),
        .write_data       (write_data),
        .fpu_write_enable (fpu_write_enable),
        .fpu_write_wid    (fpu_write_wid),
        .fpu_write_fflags (fpu_write_fflags),
        .read_wid         (read_wid),
        .fpu_read_wid     (fpu_read_wid),
        .rd_fflags        (rd_fflags),
        .rd_frm           (rd_frm),
        .fpu_read_frm     (fpu_read_frm)
    );

    csr_mach_regs csr_mach_regs_inst (
        .clk          (clk),
        .reset        (reset),
        .wr_mach_sel  (wr_mach_sel),
        .write_data   (write_data),
        .rd_mach_idx  (rd_mach_idx),
        .rd_mach_data (rd_mach_data)
    );

    csr_read_mux #(
        .CORE_ID (CORE_ID)
    ) csr_read_mux_inst (
        .rd_class     (rd_class),
        .read_wid     (read_wid),
        .read_tmask   (read_tmask),
        .cycles       (cycles),
        .instret      (instret),
        .rd_fflags    (rd_fflags),
        .rd_frm       (rd_frm),
        .rd_mach_data (rd_mach_data),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the CSR unit testbench with Verilator and run it into sim.log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module csr_unit_tb \
    && ./obj_dir/Vcsr_unit_tb > sim.log 2>&1 \
    || echo "Build or simulation run failed"
grep -q "TESTS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- verification/csr_unit_tb.sv
`timescale 1ns/10ps
`include "csr_consts.svh"

module csr_unit_tb;
    import csr_pkg::*;

    localparam int        TB_CORE_ID   = 3;
    localparam int        MAX_CYCLES   = 5000;
    localparam csr_addr_t UNKNOWN_ADDR = 12'h7C0;

    logic      clk;
    logic      reset;
    logic      read_enable;
    wid_t      read_wid;
    tmask_t    read_tmask;
    csr_addr_t read_addr;
    xlen_t     read_data_ro;
    xlen_t     read_data_rw;
    logic      read_addr_valid;
    logic      write_enable;
    wid_t      write_wid;
    csr_addr_t write_addr;
    xlen_t     write_data;
    logic      fpu_write_enable;
    wid_t      fpu_write_wid;
    fflags_t   fpu_write_fflags;
    wid_t      fpu_read_wid;
    frm_t      fpu_read_frm;
    perf_ctr_t cycles;
    perf_ctr_t instret;

    // Reference model state
    fflags_t   model_fflags [`NUM_WARPS];
    frm_t      model_frm [`NUM_WARPS];
    xlen_t     model_mach [`MACH_REGS];
    csr_addr_t mach_addr [`MACH_REGS];

    int          checks;
    int          errors;
    int          test_errors;

    csr_unit #(
        .CORE_ID (TB_CORE_ID)
    ) csr_unit_inst (
        .clk              (clk),
        .reset            (reset),
        .read_enable      (read_enable),
        .read_wid         (read_wid),
        .read_tmask       (read_tmask),
        .read_addr        (read_addr),
        .read_data_ro     (read_data_ro),
        .read_data_rw     (read_data_rw),
        .read_addr_valid  (read_addr_valid),
        .write_enable     (write_enable),
        .write_wid        (write_wid),
        .write_addr       (write_addr),
        .write_data       (write_data),
        .fpu_write_enable (fpu_write_enable),
        .fpu_write_wid    (fpu_write_wid),
        .fpu_write_fflags (fpu_write_fflags),
        .fpu_read_wid     (fpu_read_wid),
        .fpu_read_frm     (fpu_read_frm),
        .cycles           (cycles),
        .instret          (instret)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog
    initial begin
        for (int n = 0; n < MAX_CYCLES; n++) begin
            @(posedge clk);
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic int mach_index(input csr_addr_t addr);
        int idx;
        idx = -1;
        for (int i = 0; i < `MACH_REGS; i++) begin
            if (mach_addr[i] == addr) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // One clock with an optional software write and FPU strobe
    task automatic write_cycle(input logic sw_en, input wid_t wid, input csr_addr_t addr,
                               input xlen_t data, input logic fpu_en, input wid_t fwid,
                               input fflags_t flags);
        int idx;
        write_enable     = sw_en;
        write_wid        = wid;
        write_addr       = addr;
        write_data       = data;
        fpu_write_enable = fpu_en;
        fpu_write_wid    = fwid;
        fpu_write_fflags = flags;
        tick();
        if (fpu_en) begin
            model_fflags[fwid] = model_fflags[fwid] | flags;
        end
        if (sw_en) begin
            idx = mach_index(addr);
            // Software flags override the FPU OR
            if (addr == `CSR_FFLAGS || addr == `CSR_FCSR) begin
                model_fflags[wid] = data[`FFLAGS_BITS-1:0];
            end
            if (addr == `CSR_FRM) begin
                model_frm[wid] = data[`FRM_BITS-1:0];
            end
            if (addr == `CSR_FCSR) begin
                model_frm[wid] = data[`FFLAGS_BITS +: `FRM_BITS];
            end
            if (idx >= 0) begin
                model_mach[idx] = data;
            end
        end
        write_enable     = 1'b0;
        fpu_write_enable = 1'b0;
    endtask

    task automatic check_read(input wid_t wid, input tmask_t tmask, input csr_addr_t addr,
                              input xlen_t exp_ro, input xlen_t exp_rw, input logic exp_valid);
        read_enable = 1'b1;
        read_wid    = wid;
        read_tmask  = tmask;
        read_addr   = addr;
        #1;
        checks++;
        assert (read_data_ro === exp_ro && read_data_rw === exp_rw
                && read_addr_valid === exp_valid)
        else begin
            errors++;
            $display("Fail at %0t: addr %h wid %0d got ro %h rw %h valid %b, want %h %h %b",
                     $time, addr, wid, read_data_ro, read_data_rw, read_addr_valid,
                     exp_ro, exp_rw, exp_valid);
        end
        tick();
    endtask

    task automatic check_fpu_frm(input wid_t wid);
        fpu_read_wid = wid;
        #1;
        checks++;
        assert (fpu_read_frm === model_frm[wid])
        else begin
            errors++;
            $display("Fail at %0t: fpu_read_frm for warp %0d is %0d, want %0d",
                     $time, wid, fpu_read_frm, model_frm[wid]);
        end
        tick();
    endtask

    // All warps' floating-point CSRs plus the FPU rounding-mode port
    task automatic check_fp_all();
        for (int w = 0; w < `NUM_WARPS; w++) begin
            check_read(wid_t'(w), '0, `CSR_FFLAGS, '0, xlen_t'(model_fflags[w]), 1'b1);
            check_read(wid_t'(w), '0, `CSR_FRM, '0, xlen_t'(model_frm[w]), 1'b1);
            check_read(wid_t'(w), '0, `CSR_FCSR, '0,
                       xlen_t'({model_frm[w], model_fflags[w]}), 1'b1);
        end
        check_fpu_frm(wid_t'($urandom));
    endtask

    task automatic check_mach_all();
        for (int i = 0; i < `MACH_REGS; i++) begin
            check_read(wid_t'($urandom), '0, mach_addr[i], model_mach[i], '0, 1'b1);
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %-16s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        wid_t      w;
        tmask_t    tm;
        xlen_t     data;
        csr_addr_t addr;
        void'($urandom(32'h9200_822b));
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        mach_addr = '{`CSR_SATP, `CSR_MSTATUS, `CSR_MEDELEG, `CSR_MIDELEG, `CSR_MIE,
                      `CSR_MTVEC, `CSR_MEPC, `CSR_PMPCFG0, `CSR_PMPADDR0};
        for (int i = 0; i < `NUM_WARPS; i++) begin
            model_fflags[i] = '0;
            model_frm[i]    = '0;
        end
        for (int i = 0; i < `MACH_REGS; i++) begin
            model_mach[i] = '0;
        end
        reset            = 1'b1;
        read_enable      = 1'b0;
        read_wid         = '0;
        read_tmask       = '0;
        read_addr        = '0;
        write_enable     = 1'b0;
        write_wid        = '0;
        write_addr       = '0;
        write_data       = '0;
        fpu_write_enable = 1'b0;
        fpu_write_wid    = '0;
        fpu_write_fflags = '0;
        fpu_read_wid     = '0;
        cycles           = '0;
        instret          = '0;
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;

        check_fp_all();
        check_mach_all();
        for (int w2 = 0; w2 < `NUM_WARPS; w2++) begin
            check_fpu_frm(wid_t'(w2));
        end
        finish_test("reset");

        for (int i = 0; i < `MACH_REGS; i++) begin
            write_cycle(1'b1, wid_t'($urandom), mach_addr[i], $urandom, 1'b0, '0, '0);
        end
        check_mach_all();
        write_cycle(1'b1, '0, UNKNOWN_ADDR, $urandom, 1'b0, '0, '0);
        check_mach_all();
        check_fp_all();
        finish_test("machine regs");

        for (int i = 0; i < 12; i++) begin
            case ($urandom % 3)
                0: addr = `CSR_FFLAGS;
                1: addr = `CSR_FRM;
                default: addr = `CSR_FCSR;
            endcase
            write_cycle(1'b1, wid_t'($urandom), addr, $urandom, 1'b0, '0, '0);
            check_fp_all();
        end
        finish_test("per-warp fcsr");

        for (int i = 0; i < 6; i++) begin
            write_cycle(1'b0, '0, '0, '0, 1'b1, wid_t'($urandom), fflags_t'($urandom));
            check_fp_all();
        end
        w = wid_t'($urandom);
        write_cycle(1'b1, w, `CSR_FFLAGS, $urandom, 1'b1, w, fflags_t'($urandom));
        check_fp_all();
        write_cycle(1'b1, w, `CSR_FRM, $urandom, 1'b1, w, fflags_t'($urandom));
        check_fp_all();
        finish_test("fpu accumulate");

        w  = wid_t'($urandom);
        tm = tmask_t'($urandom);
        check_read(w, tm, `CSR_LWID, xlen_t'(w), '0, 1'b1);
        check_read(w, tm, `CSR_GWID, xlen_t'((TB_CORE_ID << `NW_BITS) + w), '0, 1'b1);
        check_read(w, tm, `CSR_GCID, xlen_t'(TB_CORE_ID), '0, 1'b1);
        check_read(w, tm, `CSR_TMASK, xlen_t'(tm), '0, 1'b1);
        check_read(w, tm, `CSR_NT, 32'd4, '0, 1'b1);
        check_read(w, tm, `CSR_NW, 32'd4, '0, 1'b1);
        check_read(w, tm, `CSR_NC, 32'd2, '0, 1'b1);
        // RV32 width code 1 in bits 31:30
        check_read(w, tm, `CSR_MISA, (32'd1 << 30) | `MISA_STD, '0, 1'b1);
        check_read(w, tm, `CSR_MVENDORID, `VENDOR_ID, '0, 1'b1);
        check_read(w, tm, `CSR_MARCHID, `ARCH_ID, '0, 1'b1);
        check_read(w, tm, `CSR_MIMPID, `IMPL_ID, '0, 1'b1);
        cycles  = perf_ctr_t'({$urandom, $urandom});
        instret = perf_ctr_t'({$urandom, $urandom});
        check_read(w, tm, `CSR_MCYCLE, cycles[31:0], '0, 1'b1);
        check_read(w, tm, `CSR_MCYCLE_H, xlen_t'(cycles >> 32), '0, 1'b1);
        check_read(w, tm, `CSR_MINSTRET, instret[31:0], '0, 1'b1);
        check_read(w, tm, `CSR_MINSTRET_H, xlen_t'(instret >> 32), '0, 1'b1);
        data = xlen_t'($urandom_range(31, 3));
        check_read(w, tm, csr_addr_t'(`CSR_MPM_BASE + data), '0, '0, 1'b1);
        data = xlen_t'($urandom_range(31, 3));
        check_read(w, tm, csr_addr_t'(`CSR_MPM_BASE_H + data), '0, '0, 1'b1);
        check_read(w, tm, UNKNOWN_ADDR, '0, '0, 1'b0);
        finish_test("read-only csrs");

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+design
design/csr_pkg.sv
design/csr_decode.sv
design/csr_fcsr_bank.sv
design/csr_mach_regs.sv
design/csr_read_mux.sv
design/csr_unit.sv
verification/csr_unit_tb.sv
